// File: flist.f
+incdir+hdl
hdl/vga_pkg.sv
hdl/vga_timing.sv
hdl/draw_start_screen.sv
hdl/vga_out.sv
hdl/start_screen_top.sv
tb/start_screen_tb.sv

// File: run.sh
#!/usr/bin/env bash
# Build and run the start screen testbench with Verilator.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module start_screen_tb -f flist.f

sim_out=$(./obj_dir/Vstart_screen_tb)
echo "$sim_out"

if echo "$sim_out" | grep -q "TESTBENCH PASSED"; then
  exit 0
fi
exit 1

// File: tb/start_screen_tb.sv
`include "vga_params.svh"

module start_screen_tb
  import vga_pkg::*;
;

  localparam int FRAME_CYCLES = `VGA_H_TOTAL * `VGA_V_TOTAL;
  localparam int PIPE_DELAY   = 3;
  localparam longint WATCHDOG_TIME = longint'(FRAME_CYCLES) * 40 * 5 / 2;

  // Stripe colors from left to right.
  localparam logic [11:0] STRIPE_REF [0:`ST_STRIPE_COUNT-1] = '{
    YELLOW_START, RED_START,    BLACK_START,  GREEN_START,  WHITE_START,
    RED_START,    BLUE_START,   WHITE_START,  RED_START,    YELLOW_START,
    BLACK_START,  YELLOW_START, GREEN_START,  RED_START,    YELLOW_START,
    BLUE_START,   BLACK_START,  WHITE_START,  GREEN_START,  RED_START,
    BLUE_START,   YELLOW_START, WHITE_START,  GREEN_START,  RED_START
  };

  logic       clk;
  logic       rst;
  logic       vga_hsync;
  logic       vga_vsync;
  logic [3:0] vga_r;
  logic [3:0] vga_g;
  logic [3:0] vga_b;

  int   cyc = 0;
  logic seen_rst = 1'b0;
  int   hits [1:6];
  int   errs [1:6];
  logic [`ST_STRIPE_COUNT-1:0] stripes_seen = '0;

  int   exp_h;
  int   exp_v;
  int   exp_idx;
  logic model_valid;
  logic exp_hsync;
  logic exp_vsync;
  logic exp_active;
  logic exp_band;
  rgb_t exp_rgb;

  start_screen_top u_dut (
    .clk       (clk),
    .rst       (rst),
    .vga_hsync (vga_hsync),
    .vga_vsync (vga_vsync),
    .vga_r     (vga_r),
    .vga_g     (vga_g),
    .vga_b     (vga_b)
  );

  always #20 clk = ~clk;

  // Cycle 0 is the first edge with rst low.
  always @(posedge clk) begin
    if (rst) begin
      cyc      <= 0;
      seen_rst <= 1'b1;
    end else begin
      cyc <= cyc + 1;
    end
  end

  // Pixel expected at the ports for the current cycle.
  always_comb begin
    model_valid = (cyc >= PIPE_DELAY);
    exp_h = (cyc - PIPE_DELAY) % `VGA_H_TOTAL;
    exp_v = ((cyc - PIPE_DELAY) / `VGA_H_TOTAL) % `VGA_V_TOTAL;
    exp_hsync = (exp_h >= `VGA_H_ACTIVE + `VGA_H_FRONT) &&
                (exp_h < `VGA_H_ACTIVE + `VGA_H_FRONT + `VGA_H_SYNC);
    exp_vsync = (exp_v >= `VGA_V_ACTIVE + `VGA_V_FRONT) &&
                (exp_v < `VGA_V_ACTIVE + `VGA_V_FRONT + `VGA_V_SYNC);
    exp_active = (exp_h < `VGA_H_ACTIVE) && (exp_v < `VGA_V_ACTIVE);
    exp_band = (exp_v >= `ST_STRIPE_HEIGHT) &&
               (exp_v <= `VGA_V_ACTIVE - `ST_STRIPE_HEIGHT);
    exp_idx = exp_h / `ST_STRIPE_WIDTH;
    if (exp_idx > `ST_STRIPE_COUNT - 1) begin
      exp_idx = `ST_STRIPE_COUNT - 1;
    end
    exp_rgb.word = exp_band ? WHITE_START : STRIPE_REF[exp_idx];
  end

  task automatic record_mismatch(input int k, input string sig,
                                 input logic [15:0] exp_val, input logic [15:0] got_val);
    $display("[FAIL] %s expected %h got %h at time %0t", sig, exp_val, got_val, $time);
    errs[k] += 1;
  endtask

  a_reset_levels: assert property (@(posedge clk)
    (seen_rst && cyc < 2) |-> ({vga_hsync, vga_vsync, vga_r, vga_g, vga_b} == 14'h0))
    else record_mismatch(1, "{vga_hsync,vga_vsync,vga_r,vga_g,vga_b}", 16'h0,
                         16'($sampled({vga_hsync, vga_vsync, vga_r, vga_g, vga_b})));

  a_hsync: assert property (@(posedge clk) model_valid |-> (vga_hsync == exp_hsync))
    else record_mismatch(2, "vga_hsync", 16'($sampled(exp_hsync)), 16'($sampled(vga_hsync)));

  a_vsync: assert property (@(posedge clk) model_valid |-> (vga_vsync == exp_vsync))
    else record_mismatch(3, "vga_vsync", 16'($sampled(exp_vsync)), 16'($sampled(vga_vsync)));

  a_blank: assert property (@(posedge clk)
    (model_valid && !exp_active) |-> ({vga_r, vga_g, vga_b} == 12'h000))
    else record_mismatch(4, "{vga_r,vga_g,vga_b}", 16'h0, 16'($sampled({vga_r, vga_g, vga_b})));

  a_stripes: assert property (@(posedge clk)
    (model_valid && exp_active && !exp_band) |-> ({vga_r, vga_g, vga_b} == exp_rgb.word))
    else record_mismatch(5, "{vga_r,vga_g,vga_b}", 16'($sampled(exp_rgb.word)),
                         16'($sampled({vga_r, vga_g, vga_b})));

  a_band: assert property (@(posedge clk)
    (model_valid && exp_active && exp_band) |-> ({vga_r, vga_g, vga_b} == WHITE_START))
    else record_mismatch(6, "{vga_r,vga_g,vga_b}", 16'(WHITE_START),
                         16'($sampled({vga_r, vga_g, vga_b})));

  // How often each check was reached.
  always @(posedge clk) begin
    if (seen_rst && cyc < 2) hits[1] += 1;
    if (model_valid) hits[2] += 1;
    if (model_valid) hits[3] += 1;
    if (model_valid && !exp_active) hits[4] += 1;
    if (model_valid && exp_active && !exp_band) begin
      hits[5] += 1;
      stripes_seen[exp_idx] <= 1'b1;
    end
    if (model_valid && exp_active && exp_band) hits[6] += 1;
  end

  task automatic print_result(input int k, input string name);
    if (hits[k] == 0) begin
      $display("test %0d %s: FAIL, the check was never reached", k, name);
    end else if (errs[k] != 0) begin
      $display("test %0d %s: FAIL, %0d of %0d checks wrong", k, name, errs[k], hits[k]);
    end else begin
      $display("test %0d %s: PASS, %0d checks", k, name, hits[k]);
    end
  endtask

  initial begin
    #(WATCHDOG_TIME);
    $display("Watchdog expired before two frames were checked.");
    $display("TESTBENCH FAILED");
    $finish;
  end

  initial begin
    int failed;
    clk = 1'b0;
    rst = 1'b1;
    for (int k = 1; k <= 6; k++) begin
      hits[k] = 0;
      errs[k] = 0;
    end
    repeat (2) @(posedge clk);
    rst <= 1'b0;
    // Two whole frames past the pipeline fill.
    repeat (2 * FRAME_CYCLES + PIPE_DELAY + 1) @(posedge clk);
    #1;
    if (stripes_seen != '1) begin
      $display("Not every stripe was drawn on the top and bottom bands.");
      errs[5] += 1;
    end
    print_result(1, "reset levels");
    print_result(2, "horizontal sync");
    print_result(3, "vertical sync");
    print_result(4, "black outside active area");
    print_result(5, "stripe colors");
    print_result(6, "white middle band");
    failed = 0;
    for (int k = 1; k <= 6; k++) begin
      if (hits[k] == 0 || errs[k] != 0) failed++;
    end
    $display("Tests run: 6, passed: %0d, failed: %0d", 6 - failed, failed);
    if (failed == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

// File: hdl/start_screen_top.sv
`include "vga_params.svh"

module start_screen_top
  import vga_pkg::*;
(
  input  logic       clk,
  input  logic       rst,
  output logic       vga_hsync,
  output logic       vga_vsync,
  output logic [3:0] vga_r,
  output logic [3:0] vga_g,
  output logic [3:0] vga_b
);

  // Timing generator to drawing stage.
  logic [`VGA_CNT_W-1:0] tim_hcount;
  logic [`VGA_CNT_W-1:0] tim_vcount;
  logic                  tim_hsync;
  logic                  tim_vsync;
  logic                  tim_hblnk;
  logic                  tim_vblnk;

  // Drawing stage to output stage.
  logic                  drw_hsync;
  logic                  drw_vsync;
  logic                  drw_hblnk;
  logic                  drw_vblnk;
  rgb_t                  drw_rgb;

  vga_timing u_vga_timing (
    .clk    (clk),
    .rst    (rst),
    .hcount (tim_hcount),
    .vcount (tim_vcount),
    .hsync  (tim_hsync),
    .vsync  (tim_vsync),
    .hblnk  (tim_hblnk),
    .vblnk  (tim_vblnk)
  );

  draw_start_screen u_draw_start_screen (
    .clk       (clk),
    .rst       (rst),
    .hcount_in (tim_hcount),
    .vcount_in (tim_vcount),
    .hsync_in  (tim_hsync),
    .vsync_in  (tim_vsync),
    .hblnk_in  (tim_hblnk),
    .vblnk_in  (tim_vblnk),
    .hcount    (),
    .vcount    (),
    .hsync     (drw_hsync),
    .vsync     (drw_vsync),
    .hblnk     (drw_hblnk),
    .vblnk     (drw_vblnk),
    .rgb       (drw_rgb)
  );

  // Counts end at the drawing stage; the output side needs only levels.
  vga_out u_vga_out (
    .clk       (clk),
    .rst       (rst),
    .hsync_in  (drw_hsync),
    .vsync_in  (drw_vsync),
    .hblnk     (drw_hblnk),
    .vblnk     (drw_vblnk),
    .rgb       (drw_rgb),
    .vga_hsync (vga_hsync),
    .vga_vsync (vga_vsync),
    .vga_r     (vga_r),
    .vga_g     (vga_g),
    .vga_b     (vga_b)
  );

endmodule

// File: hdl/vga_out.sv
module vga_out
  import vga_pkg::*;
(
  input  logic       clk,
  input  logic       rst,
  input  logic       hsync_in,
  input  logic       vsync_in,
  input  logic       hblnk,
  input  logic       vblnk,
  input  rgb_t       rgb,
  output logic       vga_hsync,
  output logic       vga_vsync,
  output logic [3:0] vga_r,
  output logic [3:0] vga_g,
  output logic [3:0] vga_b
);

  logic blank;

  assign blank = hblnk || vblnk;

  // Black outside the visible area.
  always_ff @(posedge clk) begin
    if (rst) begin
      vga_hsync <= 1'b0;
      vga_vsync <= 1'b0;
      vga_r     <= '0;
      vga_g     <= '0;
      vga_b     <= '0;
    end else begin
      vga_hsync <= hsync_in;
      vga_vsync <= vsync_in;
      vga_r     <= blank ? 4'h0 : rgb.ch.red;
      vga_g     <= blank ? 4'h0 : rgb.ch.green;
      vga_b     <= blank ? 4'h0 : rgb.ch.blue;
    end
  end

  a_blank_black: assert property (
    @(posedge clk) disable iff (rst)
    blank |=> (vga_r == 4'h0) && (vga_g == 4'h0) && (vga_b == 4'h0)
  );

endmodule

// File: hdl/draw_start_screen.sv
`include "vga_params.svh"

module draw_start_screen
  import vga_pkg::*;
(
  input  logic                  clk,
  input  logic                  rst,
  input  logic [`VGA_CNT_W-1:0] hcount_in,
  input  logic [`VGA_CNT_W-1:0] vcount_in,
  input  logic                  hsync_in,
  input  logic                  vsync_in,
  input  logic                  hblnk_in,
  input  logic                  vblnk_in,
  output logic [`VGA_CNT_W-1:0] hcount,
  output logic [`VGA_CNT_W-1:0] vcount,
  output logic                  hsync,
  output logic                  vsync,
  output logic                  hblnk,
  output logic                  vblnk,
  output rgb_t                  rgb
);

  localparam int SEL_W    = $clog2(`ST_STRIPE_COUNT);
  localparam int LAST_IDX = `ST_STRIPE_COUNT - 1;
  localparam int BAND_TOP = `ST_STRIPE_HEIGHT;
  localparam int BAND_BOT = `VGA_V_ACTIVE - `ST_STRIPE_HEIGHT;

  // Stripe colors from left to right.
  localparam logic [11:0] STRIPE_COLORS [0:`ST_STRIPE_COUNT-1] = '{
    YELLOW_START, RED_START,    BLACK_START,  GREEN_START,  WHITE_START,
    RED_START,    BLUE_START,   WHITE_START,  RED_START,    YELLOW_START,
    BLACK_START,  YELLOW_START, GREEN_START,  RED_START,    YELLOW_START,
    BLUE_START,   BLACK_START,  WHITE_START,  GREEN_START,  RED_START,
    BLUE_START,   YELLOW_START, WHITE_START,  GREEN_START,  RED_START
  };

  logic [`VGA_CNT_W-1:0] stripe_idx;
  logic [SEL_W-1:0]      stripe_sel;
  logic                  in_band;
  rgb_t                  rgb_nxt;

  assign stripe_idx = hcount_in / `ST_STRIPE_WIDTH;

  // Everything past the last stripe boundary keeps the last color.
  assign stripe_sel = (stripe_idx >= LAST_IDX) ? SEL_W'(LAST_IDX) : stripe_idx[SEL_W-1:0];

  assign in_band = (vcount_in >= BAND_TOP) && (vcount_in <= BAND_BOT);

  always_comb begin
    rgb_nxt.word = STRIPE_COLORS[stripe_sel];
    if (in_band) begin
      rgb_nxt.word = WHITE_START;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      hcount <= '0;
      vcount <= '0;
      hsync  <= 1'b0;
      vsync  <= 1'b0;
      hblnk  <= 1'b0;
      vblnk  <= 1'b0;
      rgb    <= '0;
    end else begin
      hcount <= hcount_in;
      vcount <= vcount_in;
      hsync  <= hsync_in;
      vsync  <= vsync_in;
      hblnk  <= hblnk_in;
      vblnk  <= vblnk_in;
      rgb    <= rgb_nxt;
    end
  end

endmodule

// File: hdl/vga_timing.sv
`include "vga_params.svh"

module vga_timing (
  input  logic                  clk,
  input  logic                  rst,
  output logic [`VGA_CNT_W-1:0] hcount,
  output logic [`VGA_CNT_W-1:0] vcount,
  output logic                  hsync,
  output logic                  vsync,
  output logic                  hblnk,
  output logic                  vblnk
);

  localparam int H_SYNC_START = `VGA_H_ACTIVE + `VGA_H_FRONT;
  localparam int H_SYNC_END   = H_SYNC_START + `VGA_H_SYNC - 1;
  localparam int V_SYNC_START = `VGA_V_ACTIVE + `VGA_V_FRONT;
  localparam int V_SYNC_END   = V_SYNC_START + `VGA_V_SYNC - 1;

  logic [`VGA_CNT_W-1:0] h_cnt;
  logic [`VGA_CNT_W-1:0] v_cnt;
  logic                  h_last;
  logic                  v_last;

  assign h_last = (h_cnt == `VGA_H_TOTAL - 1);
  assign v_last = (v_cnt == `VGA_V_TOTAL - 1);

  // Free-running pixel position.
  always_ff @(posedge clk) begin
    if (rst) begin
      h_cnt <= '0;
      v_cnt <= '0;
    end else if (h_last) begin
      h_cnt <= '0;
      v_cnt <= v_last ? '0 : v_cnt + 1'b1;
    end else begin
      h_cnt <= h_cnt + 1'b1;
    end
  end

  // Counts with their sync and blanking decodes, one register stage.
  always_ff @(posedge clk) begin
    if (rst) begin
      hcount <= '0;
      vcount <= '0;
      hsync  <= 1'b0;
      vsync  <= 1'b0;
      hblnk  <= 1'b0;
      vblnk  <= 1'b0;
    end else begin
      hcount <= h_cnt;
      vcount <= v_cnt;
      hsync  <= (h_cnt >= H_SYNC_START) && (h_cnt <= H_SYNC_END);
      vsync  <= (v_cnt >= V_SYNC_START) && (v_cnt <= V_SYNC_END);
      hblnk  <= (h_cnt >= `VGA_H_ACTIVE);
      vblnk  <= (v_cnt >= `VGA_V_ACTIVE);
    end
  end

  // Presented position never leaves the frame.
  a_count_range: assert property (
    @(posedge clk) disable iff (rst)
    (hcount < `VGA_H_TOTAL) && (vcount < `VGA_V_TOTAL)
  );

endmodule

// File: hdl/vga_pkg.sv
package vga_pkg;

  // Per channel view of a pixel color.
  typedef struct packed {
    logic [3:0] red;
    logic [3:0] green;
    logic [3:0] blue;
  } rgb_ch_t;

  // 12-bit color, seen as one word or as three channels.
  typedef union packed {
    logic [11:0] word;
    rgb_ch_t     ch;
  } rgb_t;

  // Start screen palette.
  localparam logic [11:0] BLACK_START  = 12'h000;
  localparam logic [11:0] WHITE_START  = 12'hfff;
  localparam logic [11:0] RED_START    = 12'hf00;
  localparam logic [11:0] GREEN_START  = 12'h0f0;
  localparam logic [11:0] BLUE_START   = 12'h00f;
  localparam logic [11:0] YELLOW_START = 12'hff0;

endpackage

// File: hdl/vga_params.svh
`ifndef VGA_PARAMS_SVH
`define VGA_PARAMS_SVH

// Horizontal timing, 800x600 at 60 Hz, 40 MHz pixel clock.
`define VGA_H_ACTIVE 800
`define VGA_H_FRONT 40
`define VGA_H_SYNC 128
`define VGA_H_TOTAL 1056

// Vertical timing in lines.
`define VGA_V_ACTIVE 600
`define VGA_V_FRONT 1
`define VGA_V_SYNC 4
`define VGA_V_TOTAL 628

// Width of both pixel counters.
`define VGA_CNT_W 11

// Start screen stripe geometry.
`define ST_STRIPE_WIDTH 32
`define ST_STRIPE_COUNT 25
`define ST_STRIPE_HEIGHT 64

`endif
